// File: lsb_pkg.sv
package lsb_pkg;

    localparam int SLOT_NUM  = 16;
    localparam int TAG_W     = $clog2(SLOT_NUM);
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int IMM_W     = 12;
    localparam int MEM_BYTES = 1024;
    localparam int MEM_AW    = $clog2(MEM_BYTES);

    // byte at address a starts as a[7:0] ^ MEM_INIT_XOR
    localparam logic [7:0] MEM_INIT_XOR = 8'h5a;

    typedef logic [TAG_W-1:0]        tag_t;      // slot index, 0 = no producer
    typedef logic [DATA_W-1:0]       data_t;
    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic signed [IMM_W-1:0] imm_t;
    typedef logic [3:0]              op_t;
    typedef logic [1:0]              len_t;
    typedef logic [MEM_AW-1:0]       mem_addr_t; // address bits that reach the memory

    // low 3 bits follow funct3, bit 3 marks a store
    localparam op_t OP_LB  = 4'h0;
    localparam op_t OP_LH  = 4'h1;
    localparam op_t OP_LW  = 4'h2;
    localparam op_t OP_LBU = 4'h4;
    localparam op_t OP_LHU = 4'h5;
    localparam op_t OP_SB  = 4'h8;
    localparam op_t OP_SH  = 4'h9;
    localparam op_t OP_SW  = 4'ha;

    localparam len_t LEN_ONE  = 2'd0;
    localparam len_t LEN_TWO  = 2'd1;
    localparam len_t LEN_FOUR = 2'd2;

    function automatic logic is_load_op(op_t op);
        case (op)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: return 1'b1;
            default:                             return 1'b0;
        endcase
    endfunction

    function automatic logic is_store_op(op_t op);
        case (op)
            OP_SB, OP_SH, OP_SW: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

endpackage

// File: lsb_entries.sv
`timescale 1ns/10ps

module lsb_entries import lsb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clr,
    input  logic                 dp_en,
    input  op_t                  dp_op,
    input  imm_t                 dp_imm,
    input  tag_t                 dp_tag,
    input  tag_t                 dp_rs1_tag,
    input  data_t                dp_rs1_data,
    input  tag_t                 dp_rs2_tag,
    input  data_t                dp_rs2_data,
    input  logic                 ex_en,
    input  tag_t                 ex_tag,
    input  data_t                ex_data,
    input  logic                 res_en,
    input  tag_t                 res_tag,
    input  data_t                res_data,
    input  logic                 commit_en,
    input  tag_t                 commit_tag,
    input  logic                 issue_en,
    input  tag_t                 issue_tag,
    input  logic                 free_en,
    input  tag_t                 free_tag,
    output logic [SLOT_NUM-1:0]  busy,
    output logic [SLOT_NUM-1:0]  rdy1,
    output logic [SLOT_NUM-1:0]  rdy2,
    output logic [SLOT_NUM-1:0]  committed,
    output logic [SLOT_NUM-1:0]  issued,
    output logic [SLOT_NUM-1:0]  is_store,
    output op_t   [SLOT_NUM-1:0] op,
    output imm_t  [SLOT_NUM-1:0] imm,
    output data_t [SLOT_NUM-1:0] rs1_data,
    output data_t [SLOT_NUM-1:0] rs2_data
);

    tag_t [SLOT_NUM-1:0] wait1;    // producer tags, meaningful while not ready
    tag_t [SLOT_NUM-1:0] wait2;
    logic [SLOT_NUM-1:0] ex_hit1, ex_hit2, res_hit1, res_hit2;
    logic                dp_ok;
    logic                dp_v1, dp_v2;
    data_t               dp_d1, dp_d2;

    assign dp_ok = dp_en && (is_load_op(dp_op) || is_store_op(dp_op));

    // {valid, data} of a source at dispatch, catches a broadcast in the same cycle
    function automatic logic [DATA_W:0] dp_src(tag_t t, data_t d);
        if (t == '0)
            return {1'b1, d};
        if (ex_en && ex_tag == t)
            return {1'b1, ex_data};
        if (res_en && res_tag == t)
            return {1'b1, res_data};
        return {1'b0, d};
    endfunction

    always_comb begin
        {dp_v1, dp_d1} = dp_src(dp_rs1_tag, dp_rs1_data);
        {dp_v2, dp_d2} = dp_src(dp_rs2_tag, dp_rs2_data);
    end

    // wakeup compare, every waiting operand against both buses
    always_comb begin
        for (int i = 0; i < SLOT_NUM; i++) begin
            ex_hit1[i]  = ex_en && ex_tag == wait1[i] && busy[i] && !rdy1[i];
            ex_hit2[i]  = ex_en && ex_tag == wait2[i] && busy[i] && !rdy2[i];
            res_hit1[i] = res_en && res_tag == wait1[i] && busy[i] && !rdy1[i];
            res_hit2[i] = res_en && res_tag == wait2[i] && busy[i] && !rdy2[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || clr) begin
            busy      <= '0;
            rdy1      <= '0;
            rdy2      <= '0;
            committed <= '0;
            issued    <= '0;
            is_store  <= '0;
        end else begin
            rdy1 <= rdy1 | ex_hit1 | res_hit1;
            rdy2 <= rdy2 | ex_hit2 | res_hit2;
            if (commit_en)
                committed[commit_tag] <= 1'b1;
            if (issue_en) begin
                if (is_store[issue_tag])
                    busy[issue_tag] <= 1'b0;    // stores leave at issue
                else
                    issued[issue_tag] <= 1'b1;
            end
            if (free_en)
                busy[free_tag] <= 1'b0;
            if (dp_ok) begin
                busy[dp_tag]      <= 1'b1;
                rdy1[dp_tag]      <= dp_v1;
                rdy2[dp_tag]      <= dp_v2;
                committed[dp_tag] <= 1'b0;
                issued[dp_tag]    <= 1'b0;
                is_store[dp_tag]  <= is_store_op(dp_op);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOT_NUM; i++) begin
            if (ex_hit1[i])
                rs1_data[i] <= ex_data;
            else if (res_hit1[i])
                rs1_data[i] <= res_data;
            if (ex_hit2[i])
                rs2_data[i] <= ex_data;
            else if (res_hit2[i])
                rs2_data[i] <= res_data;
        end
        if (dp_ok) begin
            op[dp_tag]       <= dp_op;
            imm[dp_tag]      <= dp_imm;
            wait1[dp_tag]    <= dp_rs1_tag;
            wait2[dp_tag]    <= dp_rs2_tag;
            rs1_data[dp_tag] <= dp_d1;
            rs2_data[dp_tag] <= dp_d2;
        end
    end

    // dispatch only lands in a free, real slot, which also rules out dispatch while full
    assert property (@(posedge clk) disable iff (!rst_n || clr)
        dp_ok |-> dp_tag != '0 && !busy[dp_tag]);

endmodule

// File: lsb_select.sv
`timescale 1ns/10ps

module lsb_select import lsb_pkg::*; (
    input  logic [SLOT_NUM-1:0] busy,
    input  logic [SLOT_NUM-1:0] rdy1,
    input  logic [SLOT_NUM-1:0] rdy2,
    input  logic [SLOT_NUM-1:0] committed,
    input  logic [SLOT_NUM-1:0] issued,
    input  logic [SLOT_NUM-1:0] is_store,
    input  logic                issue_en,
    input  tag_t                issue_tag,
    output logic                ld_hit,
    output tag_t                ld_tag,
    output logic                st_hit,
    output tag_t                st_tag
);

    logic [SLOT_NUM-1:0] in_flight;    // slot whose request is on the dc bus now
    logic [SLOT_NUM-1:0] ld_cand;
    logic [SLOT_NUM-1:0] st_cand;

    always_comb begin
        in_flight = '0;
        if (issue_en)
            in_flight[issue_tag] = 1'b1;
    end

    assign ld_cand = busy & ~is_store & ~issued & rdy1 & ~in_flight;
    assign st_cand = busy & is_store & committed & rdy1 & rdy2 & ~in_flight;

    // walk down so the lowest slot number wins, slot 0 is never used
    always_comb begin
        ld_hit = 1'b0;
        ld_tag = '0;
        st_hit = 1'b0;
        st_tag = '0;
        for (int i = SLOT_NUM - 1; i >= 1; i--) begin
            if (ld_cand[i]) begin
                ld_hit = 1'b1;
                ld_tag = tag_t'(i);
            end
            if (st_cand[i]) begin
                st_hit = 1'b1;
                st_tag = tag_t'(i);
            end
        end
    end

endmodule

// File: lsb_agu.sv
`timescale 1ns/10ps

module lsb_agu import lsb_pkg::*; (
    input  tag_t                 sel_tag,
    input  op_t   [SLOT_NUM-1:0] op,
    input  imm_t  [SLOT_NUM-1:0] imm,
    input  data_t [SLOT_NUM-1:0] rs1_data,
    input  data_t [SLOT_NUM-1:0] rs2_data,
    output addr_t                addr,
    output len_t                 len,
    output data_t                st_data,
    output logic                 ld_signed
);

    op_t   sel_op;
    imm_t  sel_imm;
    addr_t imm_ext;

    assign sel_op  = op[sel_tag];
    assign sel_imm = imm[sel_tag];

    // offset is sign-extended to the full address width
    assign imm_ext = {{(ADDR_W - IMM_W){sel_imm[IMM_W-1]}}, sel_imm};
    assign addr    = rs1_data[sel_tag] + imm_ext;
    assign st_data = rs2_data[sel_tag];

    always_comb begin
        case (sel_op)
            OP_LB, OP_LBU, OP_SB: len = LEN_ONE;
            OP_LH, OP_LHU, OP_SH: len = LEN_TWO;
            default:              len = LEN_FOUR;
        endcase
    end

    // word loads need no extension either way
    assign ld_signed = (sel_op == OP_LB) || (sel_op == OP_LH);

endmodule

// File: lsb_ctrl.sv
`timescale 1ns/10ps

module lsb_ctrl import lsb_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clr,
    input  logic                ld_hit,
    input  tag_t                ld_tag,
    input  logic                st_hit,
    input  tag_t                st_tag,
    input  addr_t               addr,
    input  len_t                len,
    input  data_t               st_data,
    input  logic                ld_signed,
    input  logic [SLOT_NUM-1:0] busy,
    input  data_t               mem_rd_data,
    output logic                issue_en,
    output tag_t                issue_tag,
    output logic                dc_en,
    output logic                dc_store,
    output tag_t                dc_tag,
    output len_t                dc_len,
    output addr_t               dc_addr,
    output data_t               dc_data,
    output logic                free_en,
    output tag_t                free_tag,
    output logic                res_en,
    output tag_t                res_tag,
    output data_t               res_data,
    output logic                full
);

    logic  p2_vld;     // load waiting for its memory read
    tag_t  p2_tag;
    len_t  p2_len;
    logic  p2_signed;
    data_t ext_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || clr) begin
            issue_en <= 1'b0;
            dc_store <= 1'b0;
            p2_vld   <= 1'b0;
            res_en   <= 1'b0;
        end else begin
            issue_en <= st_hit || ld_hit;
            dc_store <= st_hit;    // committed store beats any load
            p2_vld   <= issue_en && !dc_store;
            res_en   <= p2_vld;
        end
    end

    always_ff @(posedge clk) begin
        issue_tag <= st_hit ? st_tag : ld_tag;
        p2_tag    <= issue_tag;
        p2_len    <= len;
        p2_signed <= ld_signed;
        res_tag   <= p2_tag;
        res_data  <= ext_data;
    end

    // the chosen slot's fields stay put while its request is out
    assign dc_en   = issue_en;
    assign dc_tag  = issue_tag;
    assign dc_len  = len;
    assign dc_addr = addr;
    assign dc_data = st_data;

    always_comb begin
        case (p2_len)
            LEN_ONE: ext_data = {{24{p2_signed & mem_rd_data[7]}}, mem_rd_data[7:0]};
            LEN_TWO: ext_data = {{16{p2_signed & mem_rd_data[15]}}, mem_rd_data[15:0]};
            default: ext_data = mem_rd_data;
        endcase
    end

    assign free_en  = p2_vld;    // slot leaves on the edge that raises res_en
    assign free_tag = p2_tag;
    assign full     = &busy[SLOT_NUM-1:1];

    // a store gives up its slot at issue, so no result can follow it
    assert property (@(posedge clk) disable iff (!rst_n)
        dc_en && dc_store |=> !busy[$past(dc_tag)]);

    // released slot must still be held by its load in the entry array
    assert property (@(posedge clk) disable iff (!rst_n)
        free_en |-> busy[free_tag]);

endmodule

// File: lsb_dmem.sv
`timescale 1ns/10ps

module lsb_dmem import lsb_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  dc_en,
    input  logic  dc_store,
    input  len_t  dc_len,
    input  addr_t dc_addr,
    input  data_t dc_data,
    output data_t mem_rd_data
);

    logic [7:0] mem [MEM_BYTES];
    mem_addr_t  a0, a1, a2, a3;

    // upper address bits are dropped, lanes wrap inside the array
    assign a0 = dc_addr[MEM_AW-1:0];
    assign a1 = a0 + mem_addr_t'(1);
    assign a2 = a0 + mem_addr_t'(2);
    assign a3 = a0 + mem_addr_t'(3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_BYTES; i++)
                mem[i] <= 8'(i) ^ MEM_INIT_XOR;
        end else if (dc_en && dc_store) begin
            mem[a0] <= dc_data[7:0];    // little endian
            if (dc_len != LEN_ONE)
                mem[a1] <= dc_data[15:8];
            if (dc_len == LEN_FOUR) begin
                mem[a2] <= dc_data[23:16];
                mem[a3] <= dc_data[31:24];
            end
        end
    end

    // full word is read, ctrl trims it to the access length
    always_ff @(posedge clk) begin
        if (dc_en && !dc_store)
            mem_rd_data <= {mem[a3], mem[a2], mem[a1], mem[a0]};
    end

endmodule

// File: lsb_top.sv
`timescale 1ns/10ps

module lsb_top import lsb_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clr,
    input  logic  dp_en,
    input  op_t   dp_op,
    input  imm_t  dp_imm,
    input  tag_t  dp_tag,
    input  tag_t  dp_rs1_tag,
    input  data_t dp_rs1_data,
    input  tag_t  dp_rs2_tag,
    input  data_t dp_rs2_data,
    input  logic  ex_en,
    input  tag_t  ex_tag,
    input  data_t ex_data,
    input  logic  commit_en,
    input  tag_t  commit_tag,
    output logic  dc_en,
    output logic  dc_store,
    output tag_t  dc_tag,
    output len_t  dc_len,
    output addr_t dc_addr,
    output data_t dc_data,
    output logic  res_en,
    output tag_t  res_tag,
    output data_t res_data,
    output logic  full
);

    logic [SLOT_NUM-1:0] busy, rdy1, rdy2, committed, issued, is_store;
    op_t   [SLOT_NUM-1:0] op;
    imm_t  [SLOT_NUM-1:0] imm;
    data_t [SLOT_NUM-1:0] rs1_data;
    data_t [SLOT_NUM-1:0] rs2_data;

    logic  ld_hit, st_hit;
    tag_t  ld_tag, st_tag;
    logic  issue_en;
    tag_t  issue_tag;
    logic  free_en;
    tag_t  free_tag;
    addr_t addr;
    len_t  len;
    data_t st_data;
    logic  ld_signed;
    data_t mem_rd_data;

    lsb_entries u_entries (.*);

    lsb_select u_select (.*);

    // the agu follows the slot that ctrl has put on the dc bus
    lsb_agu u_agu (
        .sel_tag (issue_tag),
        .*
    );

    lsb_ctrl u_ctrl (.*);

    lsb_dmem u_dmem (.*);

endmodule

// File: lsb_checker.sv
`timescale 1ns/10ps

module lsb_checker import lsb_pkg::*; (
    input logic  clk,
    input logic  dc_en,
    input logic  dc_store,
    input tag_t  dc_tag,
    input len_t  dc_len,
    input addr_t dc_addr,
    input data_t dc_data,
    input logic  res_en,
    input tag_t  res_tag,
    input data_t res_data
);

    int    cycle = 0;
    int    pending = 0;
    int    err_cnt = 0;
    int    test_err = 0;
    int    n_tests = 0;
    tag_t  last_tag = '0;    // tag of the most recent expectation
    logic  exp_vld [SLOT_NUM] = '{default: 1'b0};
    logic  exp_st  [SLOT_NUM];
    logic  exp_iss [SLOT_NUM];    // load request already seen
    addr_t exp_addr [SLOT_NUM];
    len_t  exp_len  [SLOT_NUM];
    data_t exp_data [SLOT_NUM];
    int    exp_cyc  [SLOT_NUM];   // -1 when latency is not checked

    always @(posedge clk)
        cycle++;

    task automatic fail(string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
        test_err++;
    endtask

    task automatic expect_load(tag_t t, addr_t a, len_t l, data_t d, int c);
        exp_vld[t]  = 1'b1;
        exp_st[t]   = 1'b0;
        exp_iss[t]  = 1'b0;
        exp_addr[t] = a;
        exp_len[t]  = l;
        exp_data[t] = d;
        exp_cyc[t]  = c;
        last_tag    = t;
        pending++;
    endtask

    task automatic expect_store(tag_t t, addr_t a, len_t l, data_t d);
        expect_load(t, a, l, d, -1);
        exp_st[t] = 1'b1;
    endtask

    // clr empties every slot, so nothing more is due
    task automatic drop_expected();
        for (int i = 0; i < SLOT_NUM; i++)
            exp_vld[i] = 1'b0;
        pending = 0;
    endtask

    task automatic check_val(string what, logic got, logic exp);
        if (got !== exp)
            fail($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // outputs move on posedge, so they are stable here
    always @(negedge clk) begin
        if (dc_en === 1'b1) begin
            if (!exp_vld[dc_tag] || exp_iss[dc_tag]) begin
                $display("request for tag %0d came when none was due, at %0t", dc_tag, $time);
                err_cnt++;
                test_err++;
            end else begin
                if (dc_store !== exp_st[dc_tag] || dc_addr !== exp_addr[dc_tag]
                        || dc_len !== exp_len[dc_tag])
                    fail($sformatf("tag %0d request store %b addr %h len %0d, expected %b %h %0d",
                        dc_tag, dc_store, dc_addr, dc_len,
                        exp_st[dc_tag], exp_addr[dc_tag], exp_len[dc_tag]));
                if (exp_st[dc_tag]) begin
                    if (dc_data !== exp_data[dc_tag])
                        fail($sformatf("tag %0d store data %h, expected %h",
                            dc_tag, dc_data, exp_data[dc_tag]));
                    exp_vld[dc_tag] = 1'b0;
                    pending--;
                end else
                    exp_iss[dc_tag] = 1'b1;
            end
        end
        if (res_en === 1'b1) begin
            if (!exp_vld[res_tag] || exp_st[res_tag] || !exp_iss[res_tag]) begin
                $display("result for tag %0d came without a load request, at %0t", res_tag, $time);
                err_cnt++;
                test_err++;
            end else begin
                if (res_data !== exp_data[res_tag])
                    fail($sformatf("tag %0d result %h, expected %h",
                        res_tag, res_data, exp_data[res_tag]));
                if (exp_cyc[res_tag] >= 0 && cycle != exp_cyc[res_tag])
                    fail($sformatf("tag %0d result in cycle %0d, expected %0d",
                        res_tag, cycle, exp_cyc[res_tag]));
                exp_vld[res_tag] = 1'b0;
                pending--;
            end
        end
    end

    task automatic end_test(string name);
        n_tests++;
        if (test_err == 0)
            $display("test %0d %s: ok", n_tests, name);
        else
            $display("test %0d %s: %0d errors", n_tests, name, test_err);
        test_err = 0;
    endtask

    task automatic summary();
        $display("%0d tests run, %0d errors", n_tests, err_cnt);
    endtask

endmodule

// File: lsb_tb.sv
`timescale 1ns/10ps

module lsb_tb import lsb_pkg::*; ();

    localparam int N_OPS   = 60;                 // dispatches over all tests, rounded up
    localparam int TIMEOUT = 200 * N_OPS + 1000;

    logic  clk = 1'b0;
    logic  rst_n, clr, dp_en, ex_en, commit_en;
    op_t   dp_op;
    imm_t  dp_imm;
    tag_t  dp_tag, dp_rs1_tag, dp_rs2_tag, ex_tag, commit_tag;
    data_t dp_rs1_data, dp_rs2_data, ex_data;
    logic  dc_en, dc_store, res_en, full;
    tag_t  dc_tag, res_tag;
    len_t  dc_len;
    addr_t dc_addr;
    data_t dc_data, res_data;

    logic [31:0]         seed = 32'hd48274e7;
    logic [7:0]          mem_model [MEM_BYTES];
    logic [SLOT_NUM-1:0] used;
    int                  cyc_cnt = 0;
    op_t                 load_ops [5] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    op_t                 store_ops [3] = '{OP_SB, OP_SH, OP_SW};

    lsb_top dut (.*);

    lsb_checker chk (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt > TIMEOUT) begin
            $display("timeout, run stopped after %0d cycles", cyc_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function int pick(int n);    // 0 .. n-1
        return int'(next_rand() % 32'(n));
    endfunction

    function tag_t alloc_tag();
        tag_t t;
        t = tag_t'(next_rand());
        while (t == '0 || used[t])
            t = t + tag_t'(1);
        used[t] = 1'b1;
        return t;
    endfunction

    function automatic int op_bytes(op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic len_t op_len(op_t op);
        int n;
        n = op_bytes(op);
        return (n == 1) ? LEN_ONE : (n == 2) ? LEN_TWO : LEN_FOUR;
    endfunction

    // little endian read of the model, extended as the opcode asks
    function data_t load_value(op_t op, int a);
        logic [7:0] b0, b1;
        b0 = mem_model[a];
        b1 = mem_model[(a + 1) % MEM_BYTES];
        case (op)
            OP_LB:   return {{24{b0[7]}}, b0};
            OP_LBU:  return {24'h0, b0};
            OP_LH:   return {{16{b1[7]}}, b1, b0};
            OP_LHU:  return {16'h0, b1, b0};
            default: return {mem_model[a + 3], mem_model[a + 2], b1, b0};
        endcase
    endfunction

    task automatic write_model(int a, int n, data_t d);
        for (int i = 0; i < n; i++)
            mem_model[a + i] = d[8*i +: 8];
    endtask

    task automatic dispatch(op_t op, int imm, tag_t t, tag_t r1t, data_t r1d,
                            tag_t r2t, data_t r2d, output int cyc);
        @(negedge clk);
        dp_op       = op;
        dp_imm      = imm_t'(imm);
        dp_tag      = t;
        dp_rs1_tag  = r1t;
        dp_rs1_data = r1d;
        dp_rs2_tag  = r2t;
        dp_rs2_data = r2d;
        dp_en       = 1'b1;
        cyc         = chk.cycle;
        @(negedge clk);
        dp_en = 1'b0;
    endtask

    task automatic ex_bcast(tag_t t, data_t d);
        @(negedge clk);
        ex_tag  = t;
        ex_data = d;
        ex_en   = 1'b1;
        @(negedge clk);
        ex_en = 1'b0;
    endtask

    task automatic commit(tag_t t);
        @(negedge clk);
        commit_tag = t;
        commit_en  = 1'b1;
        @(negedge clk);
        commit_en = 1'b0;
    endtask

    task automatic wait_quiet();
        while (chk.pending > 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
        used = '0;
    endtask

    // load with its base at hand, latency checked
    task automatic load_ready(op_t op, int a, int imm);
        tag_t t;
        int   cyc;
        t = alloc_tag();
        dispatch(op, imm, t, '0, data_t'(a - imm), '0, next_rand(), cyc);
        chk.expect_load(t, addr_t'(a), op_len(op), load_value(op, a), cyc + 4);
    endtask

    initial begin
        op_t  op;
        tag_t t, p, p1, p2;
        int   a, n, imm, cyc, res_a;
        data_t d;

        rst_n = 1'b0;
        clr = 1'b0;
        dp_en = 1'b0;
        dp_op = OP_LB;
        dp_imm = '0;
        dp_tag = '0;
        dp_rs1_tag = '0;
        dp_rs1_data = '0;
        dp_rs2_tag = '0;
        dp_rs2_data = '0;
        ex_en = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        commit_en = 1'b0;
        commit_tag = '0;
        used = '0;
        for (int i = 0; i < MEM_BYTES; i++)
            mem_model[i] = 8'(i) ^ MEM_INIT_XOR;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        chk.check_val("full after reset", full, 1'b0);
        chk.check_val("dc_en after reset", dc_en, 1'b0);
        chk.check_val("res_en after reset", res_en, 1'b0);
        chk.end_test("reset state");

        for (int i = 0; i < 20; i++) begin
            op = load_ops[i % 5];
            n = op_bytes(op);
            load_ready(op, pick(512 / n) * n, (pick(64) - 32) * n);
            if (pick(2) == 0)
                wait_quiet();
        end
        wait_quiet();
        chk.end_test("loads with ready base");

        for (int i = 0; i < 4; i++) begin
            op = load_ops[pick(5)];
            n = op_bytes(op);
            a = pick(512 / n) * n;
            imm = (pick(64) - 32) * n;
            p = alloc_tag();
            t = alloc_tag();
            dispatch(op, imm, t, p, next_rand(), '0, '0, cyc);
            repeat (pick(6)) @(negedge clk);
            chk.expect_load(t, addr_t'(a), op_len(op), load_value(op, a), -1);
            ex_bcast(p, data_t'(a - imm));
            wait_quiet();
        end
        chk.end_test("load waiting on ex");

        for (int i = 0; i < 4; i++) begin
            a = pick(512);
            res_a = int'(mem_model[a]);    // LBU result feeds the next base
            imm = pick(256);
            op = (pick(2) == 0) ? OP_LB : OP_LBU;
            load_ready(OP_LBU, a, 0);
            t = alloc_tag();
            p = chk.last_tag;
            dispatch(op, imm, t, p, next_rand(), '0, '0, cyc);
            chk.expect_load(t, addr_t'(res_a + imm), LEN_ONE, load_value(op, res_a + imm), -1);
            wait_quiet();
        end
        chk.end_test("load chained on load");

        for (int i = 0; i < 4; i++) begin
            op = store_ops[pick(3)];
            n = op_bytes(op);
            a = 512 + pick(512 / n) * n;
            imm = (pick(32) - 16) * n;
            d = next_rand();
            t = alloc_tag();
            p1 = alloc_tag();
            p2 = alloc_tag();
            dispatch(op, imm, t, p1, next_rand(), p2, next_rand(), cyc);
            repeat (pick(4)) @(negedge clk);
            if (i % 2 == 1) begin    // commit before the operands arrive
                commit(t);
                ex_bcast(p1, data_t'(a - imm));
                chk.expect_store(t, addr_t'(a), op_len(op), d);
                ex_bcast(p2, d);
            end else begin
                ex_bcast(p1, data_t'(a - imm));
                ex_bcast(p2, d);
                repeat (pick(4)) @(negedge clk);
                commit(t);
                chk.expect_store(t, addr_t'(a), op_len(op), d);
            end
            wait_quiet();
            write_model(a, n, d);
            op = (n == 1) ? OP_LBU : (n == 2) ? OP_LHU : OP_LW;
            load_ready(op, a, 0);
            wait_quiet();
        end
        chk.end_test("store after commit");

        // slots 1 to 14 wait on slot 1, which never resolves
        for (int i = 1; i < SLOT_NUM - 1; i++)
            dispatch(load_ops[pick(5)], 0, tag_t'(i), tag_t'(1), '0, '0, '0, cyc);
        // last slot is a ready load, caught by clr while on the dc bus
        op = load_ops[pick(5)];
        n = op_bytes(op);
        a = pick(512 / n) * n;
        t = tag_t'(SLOT_NUM - 1);
        dispatch(op, 0, t, '0, data_t'(a), '0, '0, cyc);
        chk.expect_load(t, addr_t'(a), op_len(op), load_value(op, a), -1);
        chk.check_val("full with 15 slots", full, 1'b1);
        @(negedge clk);
        clr = 1'b1;
        @(negedge clk);
        clr = 1'b0;
        chk.drop_expected();
        repeat (10) @(negedge clk);
        chk.check_val("full after clr", full, 1'b0);
        used = '0;
        chk.end_test("full and clear");

        chk.summary();
        if (chk.err_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: lsb.f
lsb_pkg.sv
lsb_entries.sv
lsb_select.sv
lsb_agu.sv
lsb_ctrl.sv
lsb_dmem.sv
lsb_top.sv
lsb_checker.sv
lsb_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run with Verilator, pass decided from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f lsb.f --top-module lsb_tb -o lsb_sim \
    && ./obj_dir/lsb_sim > sim.log \
    && grep -q "Finished with no errors" sim.log \
    || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
